// ==== vlog.f ====
rtl/pit_pkg.sv
rtl/pit_config_if.sv
rtl/pit_count_if.sv
rtl/pit_bus_port.sv
rtl/pit_count_engine.sv
rtl/pit_out_driver.sv
rtl/pit_counter.sv
verif/pit_counter_assert.sv
verif/tb_pit_counter.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pit_counter
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f vlog.f
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/tb_pit_counter.sv ====
// Interval timer counter testbench
`timescale 1ns/100ps
`default_nettype none

module tb_pit_counter;

    // Worst case falls with the largest random preset of 40
    localparam int MAX_N         = 40;
    localparam int PLANNED_FALLS = (MAX_N + 3) + (MAX_N + 7) + (8 * MAX_N + 5) + 3 * 256 + 7;
    localparam int TIMEOUT_NS    = (PLANNED_FALLS * 8 + 400) * 4;

    logic clock;
    logic reset;
    pit_pkg::byte_t data_in;
    logic write_control;
    logic write_counter;
    logic read_counter;
    logic counter_clock;
    logic counter_gate;
    pit_pkg::byte_t read_data;
    logic counter_out;

    logic [31:0] lfsr_state;
    logic [31:0] exp_value;
    logic        exp_is_read;
    string       exp_label;
    event        sample_ev;

    pit_counter i_pit_counter (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = !clock;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the DUT did not finish the planned counter clock falls in time");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Expected {out, count} after a number of falls since the load fall
    function automatic logic [17:0] ref_model(input logic rate, input int n, input int falls);
        int count;
        logic out;
        if (falls == 0) begin
            count = 0;
            out = rate;
        end else if (!rate) begin
            count = (falls - 1 >= n) ? 0 : n - (falls - 1);
            out = (falls - 1 >= n);
        end else begin
            count = n - ((falls - 1) % n);
            out = (count != 1);
        end
        return {out, 17'(count)};
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    always @(sample_ev) begin
        if (exp_is_read)
            check_value(32'(read_data), exp_value, exp_label);
        else
            check_value(32'(counter_out), exp_value, exp_label);
    end

    task automatic expect_value(input logic is_read, input logic [31:0] value, input string what);
        exp_is_read = is_read;
        exp_value   = value;
        exp_label   = what;
        ->sample_ev;
        @(negedge clock);
    endtask

    task automatic bus_write(input logic ctrl, input pit_pkg::byte_t value);
        @(negedge clock);
        data_in       = value;
        write_control = ctrl;
        write_counter = !ctrl;
        @(negedge clock);
        write_control = 1'b0;
        write_counter = 1'b0;
        repeat (2) @(negedge clock);
    endtask

    task automatic read_pulse();
        read_counter = 1'b1;
        @(negedge clock);
        read_counter = 1'b0;
        repeat (3) @(negedge clock);
    endtask

    // One counter clock period, sampled mid low phase
    task automatic fall_tick();
        @(negedge clock);
        counter_clock = 1'b1;
        repeat (4) @(negedge clock);
        counter_clock = 1'b0;
        repeat (2) @(negedge clock);
    endtask

    task automatic run_falls(input logic rate, input int n, input int falls, input string what);
        logic [17:0] e;
        for (int f = 1; f <= falls; f++) begin
            fall_tick();
            e = ref_model(rate, n, f);
            expect_value(1'b0, 32'(e[17]), what);
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [17:0] e;
        int n;
        int k;
        int eff;
        lfsr_state = 32'h523c_5c98;
        reset = 1'b1;
        data_in = '0;
        write_control = 1'b0;
        write_counter = 1'b0;
        read_counter = 1'b0;
        counter_clock = 1'b0;
        counter_gate = 1'b1;
        repeat (10) @(negedge clock);
        reset = 1'b0;
        expect_value(1'b0, 32'd0, "counter_out after reset");
        expect_value(1'b1, 32'd0, "read_data after reset");

        // Mode 0 terminal count, then rewrite
        take_bits(6, r);
        n = 2 + int'(r % 39);
        bus_write(1'b1, 8'h30);
        bus_write(1'b0, 8'(n));
        bus_write(1'b0, 8'h00);
        expect_value(1'b0, 32'd0, "mode 0 before load fall");
        run_falls(1'b0, n, n + 3, "mode 0 terminal count");
        bus_write(1'b1, 8'h30);
        expect_value(1'b0, 32'd0, "mode 0 after control rewrite");

        // Mode 0 with a gate pause of k falls
        take_bits(6, r);
        n = 2 + int'(r % 39);
        take_bits(2, r);
        k = 1 + int'(r);
        bus_write(1'b0, 8'(n));
        bus_write(1'b0, 8'h00);
        eff = 0;
        for (int t = 1; t <= n + k + 3; t++) begin
            counter_gate = !(t >= 3 && t < 3 + k);
            fall_tick();
            if (counter_gate)
                eff++;
            e = ref_model(1'b0, n, eff);
            expect_value(1'b0, 32'(e[17]), "mode 0 gate pause");
        end

        // Mode 2 by code 6, LSB only, then gate low and restart
        take_bits(6, r);
        n = 2 + int'(r % 39);
        bus_write(1'b1, 8'h1C);
        bus_write(1'b0, 8'(n));
        expect_value(1'b0, 32'd1, "mode 2 before load fall");
        run_falls(1'b1, n, 4 * n, "mode 2 LSB rate");
        // Gate drops first in the low pulse, then right after a reload
        for (int g = 0; g < 2; g++) begin
            counter_gate = 1'b0;
            repeat (2) begin
                fall_tick();
                expect_value(1'b0, 32'd1, "mode 2 gate low");
            end
            counter_gate = 1'b1;
            run_falls(1'b1, n, 2 * n + 1 - g, "mode 2 gate restart");
        end

        // Mode 2 MSB only, preset 256
        bus_write(1'b1, 8'h24);
        bus_write(1'b0, 8'h01);
        run_falls(1'b1, 256, 3 * 256, "mode 2 MSB rate");

        // Latch and read back
        take_bits(6, r);
        n = 256 + 2 + int'(r % 39);
        bus_write(1'b1, 8'h30);
        bus_write(1'b0, 8'(n));
        bus_write(1'b0, 8'h01);
        run_falls(1'b0, n, 5, "mode 0 before latch");
        e = ref_model(1'b0, n, 5);
        bus_write(1'b1, 8'h00);
        fall_tick();
        fall_tick();
        expect_value(1'b1, 32'(e[7:0]), "latched LSB");
        read_pulse();
        expect_value(1'b1, 32'(e[15:8]), "latched MSB");
        read_pulse();
        e = ref_model(1'b0, n, 7);
        expect_value(1'b1, 32'(e[7:0]), "live LSB after latch");

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/pit_counter_assert.sv ====
// Interval timer assertions
`timescale 1ns/100ps
`default_nettype none

module pit_counter_assert (
    input wire logic                 clock,
    input wire logic                 reset,
    input wire logic                 counter_out,
    input wire pit_pkg::byte_t       read_data,
    input wire logic                 write_control,
    input wire pit_pkg::count_mode_t mode,
    input wire logic                 counting,
    input wire pit_pkg::count_t      count,
    input wire logic                 latched,
    input wire logic                 read_fall
);

    reset_outputs_low: assert property (@(posedge clock)
        reset |-> (counter_out == 1'b0 && read_data == 8'h00))
        else $error("outputs not low during reset");

    // Terminal output never drops once zero is held
    terminal_output_holds: assert property (@(posedge clock) disable iff (reset)
        (counting && mode == pit_pkg::MODE_TERMINAL && count == '0 && $past(count) == '0)
        |-> !$fell(counter_out))
        else $error("counter_out fell while the count held at zero");

    latched_read_stable: assert property (@(posedge clock) disable iff (reset)
        $past(latched && !read_fall && !write_control) |-> $stable(read_data))
        else $error("read_data changed while latched");

endmodule

bind pit_counter pit_counter_assert i_pit_counter_assert (
    .clock         (clock),
    .reset         (reset),
    .counter_out   (counter_out),
    .read_data     (read_data),
    .write_control (write_control),
    .mode          (cfg_if.mode),
    .counting      (cfg_if.counting),
    .count         (cnt_if.count),
    .latched       (i_bus_port.latched),
    .read_fall     (i_bus_port.read_fall)
);

`default_nettype wire

// ==== rtl/pit_counter.sv ====
// Interval timer counter channel
`timescale 1ns/100ps
`default_nettype none

module pit_counter (
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire pit_pkg::byte_t data_in,
    input  wire logic           write_control,
    input  wire logic           write_counter,
    input  wire logic           read_counter,
    input  wire logic           counter_clock,
    input  wire logic           counter_gate,
    output      pit_pkg::byte_t read_data,
    output      logic           counter_out
);

    pit_config_if cfg_if ();
    pit_count_if  cnt_if ();

    pit_bus_port i_bus_port (
        .clock         (clock),
        .reset         (reset),
        .data_in       (data_in),
        .write_control (write_control),
        .write_counter (write_counter),
        .read_counter  (read_counter),
        .read_data     (read_data),
        .cfg           (cfg_if.port),
        .cnt           (cnt_if.sink)
    );

    pit_count_engine i_count_engine (
        .clock         (clock),
        .reset         (reset),
        .counter_clock (counter_clock),
        .counter_gate  (counter_gate),
        .cfg           (cfg_if.sink),
        .cnt           (cnt_if.engine)
    );

    pit_out_driver i_out_driver (
        .clock       (clock),
        .reset       (reset),
        .counter_out (counter_out),
        .cfg         (cfg_if.sink),
        .cnt         (cnt_if.sink)
    );

endmodule

`default_nettype wire

// ==== rtl/pit_out_driver.sv ====
// Timer output driver
`timescale 1ns/100ps
`default_nettype none

module pit_out_driver (
    input  wire logic  clock,
    input  wire logic  reset,
    output logic       counter_out,
    pit_config_if.sink cfg,
    pit_count_if.sink  cnt
);

    logic rate_mode;

    assign rate_mode = (cfg.mode == pit_pkg::MODE_RATE);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            counter_out <= 1'b0;
        end else if (!cfg.counting) begin
            // Idle level depends on mode
            counter_out <= rate_mode;
        end else if (rate_mode) begin
            if (!cnt.gate_active)
                counter_out <= 1'b1;
            else if (cnt.count_edge)
                counter_out <= (cnt.next_count != 17'd1);
        end else if (cnt.count_edge) begin
            // Terminal count, high once zero is reached
            counter_out <= (cnt.next_count == '0);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pit_count_engine.sv ====
// Timer count engine
`timescale 1ns/100ps
`default_nettype none

module pit_count_engine (
    input  wire logic  clock,
    input  wire logic  reset,
    input  wire logic  counter_clock,
    input  wire logic  counter_gate,
    pit_config_if.sink cfg,
    pit_count_if.engine cnt
);

    logic            clock_q;
    logic            clock_qq;
    logic            count_edge;
    logic            gate_q;
    logic            gate_prev;
    logic            gate_rise;
    logic            load_pending;
    logic            take_load;
    pit_pkg::count_t count_q;
    pit_pkg::count_t dec_count;
    pit_pkg::count_t next_count;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            clock_q  <= 1'b0;
            clock_qq <= 1'b0;
            gate_q   <= 1'b0;
        end else begin
            clock_q  <= counter_clock;
            clock_qq <= clock_q;
            gate_q   <= counter_gate;
        end
    end

    assign count_edge = clock_qq && !clock_q;

    // Falls tracked at once, rises only at a count edge
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            gate_prev <= 1'b0;
        else if (count_edge || gate_prev)
            gate_prev <= gate_q;
    end

    assign gate_rise = gate_q && !gate_prev;

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            load_pending <= 1'b0;
        else if (count_edge)
            load_pending <= 1'b0;
        else if (cfg.load)
            load_pending <= 1'b1;
    end

    assign take_load = load_pending || cfg.load;
    assign dec_count = (count_q == '0) ? '0 : count_q - 17'd1;

    always_comb begin
        next_count = dec_count;
        if (cfg.mode == pit_pkg::MODE_TERMINAL && take_load)
            next_count = cfg.preset;
        else if (cfg.mode == pit_pkg::MODE_RATE && gate_rise)
            next_count = cfg.preset;
        else if (!gate_q)
            next_count = count_q;
        else if (cfg.mode == pit_pkg::MODE_RATE && dec_count == '0)
            next_count = cfg.preset;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            count_q <= '0;
        else if (!cfg.counting)
            count_q <= '0;
        else if (count_edge)
            count_q <= next_count;
    end

    assign cnt.count_edge  = count_edge;
    assign cnt.count       = count_q;
    assign cnt.next_count  = next_count;
    assign cnt.gate_active = gate_q && gate_prev;

endmodule

`default_nettype wire

// ==== rtl/pit_bus_port.sv ====
// Timer bus port
`timescale 1ns/100ps
`default_nettype none

module pit_bus_port (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire pit_pkg::byte_t  data_in,
    input  wire logic            write_control,
    input  wire logic            write_counter,
    input  wire logic            read_counter,
    output      pit_pkg::byte_t  read_data,
    pit_config_if.port           cfg,
    pit_count_if.sink            cnt
);

    pit_pkg::access_t     access_field;
    pit_pkg::mode_field_t mode_field;
    pit_pkg::count_mode_t decoded_mode;
    pit_pkg::access_t     access_q;
    pit_pkg::count_mode_t mode_q;
    logic                 is_latch;
    logic                 update_config;
    logic                 last_byte;
    logic                 write_msb;
    logic                 read_msb;
    logic                 prev_read;
    logic                 read_fall;
    logic                 latched;
    logic                 counting_q;
    logic                 load_q;
    pit_pkg::byte_t       preset_lsb;
    pit_pkg::byte_t       preset_msb;
    logic [15:0]          preset_raw;
    logic [15:0]          snapshot;

    assign access_field  = data_in[5:4];
    assign mode_field    = data_in[3:1];
    assign is_latch      = write_control && (access_field == pit_pkg::ACCESS_LATCH);
    assign update_config = write_control && (access_field != pit_pkg::ACCESS_LATCH);
    assign decoded_mode  = (mode_field == pit_pkg::MODE_FIELD_RATE ||
                            mode_field == pit_pkg::MODE_FIELD_RATE_ALT) ?
                           pit_pkg::MODE_RATE : pit_pkg::MODE_TERMINAL;
    assign last_byte     = (access_q != pit_pkg::ACCESS_LSB_MSB) || write_msb;
    assign read_fall     = prev_read && !read_counter;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            access_q   <= pit_pkg::ACCESS_LSB_MSB;
            mode_q     <= pit_pkg::MODE_TERMINAL;
            write_msb  <= 1'b0;
            read_msb   <= 1'b0;
            prev_read  <= 1'b0;
            latched    <= 1'b0;
            counting_q <= 1'b0;
            load_q     <= 1'b0;
            snapshot   <= '0;
        end else begin
            prev_read <= read_counter;
            load_q    <= write_counter && last_byte;
            if (update_config) begin
                access_q   <= access_field;
                mode_q     <= decoded_mode;
                write_msb  <= (access_field == pit_pkg::ACCESS_MSB);
                read_msb   <= (access_field == pit_pkg::ACCESS_MSB);
                counting_q <= 1'b0;
            end else begin
                if (write_counter) begin
                    if (access_q == pit_pkg::ACCESS_LSB_MSB)
                        write_msb <= !write_msb;
                    // A partial rewrite stops mode 0 but not mode 2
                    if (last_byte)
                        counting_q <= 1'b1;
                    else if (mode_q == pit_pkg::MODE_TERMINAL)
                        counting_q <= 1'b0;
                end
                if (read_fall && access_q == pit_pkg::ACCESS_LSB_MSB)
                    read_msb <= !read_msb;
            end
            if (is_latch)
                latched <= 1'b1;
            else if (read_fall && (access_q != pit_pkg::ACCESS_LSB_MSB || read_msb))
                latched <= 1'b0;
            if (!latched)
                snapshot <= cnt.count[15:0];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            preset_lsb <= '0;
            preset_msb <= '0;
        end else if (write_counter) begin
            if (write_msb)
                preset_msb <= data_in;
            else
                preset_lsb <= data_in;
        end
    end

    always_comb begin
        case (access_q)
            pit_pkg::ACCESS_LSB: preset_raw = {8'h00, preset_lsb};
            pit_pkg::ACCESS_MSB: preset_raw = {preset_msb, 8'h00};
            default:             preset_raw = {preset_msb, preset_lsb};
        endcase
    end

    // Zero preset stands for 65536
    assign cfg.preset   = (preset_raw == 16'h0000) ? {1'b1, 16'h0000} : {1'b0, preset_raw};
    assign cfg.mode     = mode_q;
    assign cfg.counting = counting_q;
    assign cfg.load     = load_q;

    assign read_data = read_msb ? snapshot[15:8] : snapshot[7:0];

endmodule

`default_nettype wire

// ==== rtl/pit_count_if.sv ====
// Count state link
`timescale 1ns/100ps
`default_nettype none

interface pit_count_if;

    logic            count_edge;
    pit_pkg::count_t count;
    pit_pkg::count_t next_count;
    logic            gate_active;

    modport engine (
        output count_edge, count, next_count, gate_active
    );

    modport sink (
        input count_edge, count, next_count, gate_active
    );

endinterface

`default_nettype wire

// ==== rtl/pit_config_if.sv ====
// Programmed configuration link
`timescale 1ns/100ps
`default_nettype none

interface pit_config_if;

    pit_pkg::count_mode_t mode;
    logic                 counting;
    pit_pkg::count_t      preset;
    logic                 load;

    modport port (
        output mode, counting, preset, load
    );

    modport sink (
        input mode, counting, preset, load
    );

endinterface

`default_nettype wire

// ==== rtl/pit_pkg.sv ====
// Interval timer shared types
`default_nettype none

package pit_pkg;

    typedef logic [7:0] byte_t;

    // Bit 16 only set for a loaded 65536
    typedef logic [16:0] count_t;

    // Read/load field, control word bits 5:4
    typedef logic [1:0] access_t;

    localparam access_t ACCESS_LATCH   = 2'd0;
    localparam access_t ACCESS_LSB     = 2'd1;
    localparam access_t ACCESS_MSB     = 2'd2;
    localparam access_t ACCESS_LSB_MSB = 2'd3;

    // Mode field, control word bits 3:1
    typedef logic [2:0] mode_field_t;

    localparam mode_field_t MODE_FIELD_RATE     = 3'd2;
    localparam mode_field_t MODE_FIELD_RATE_ALT = 3'd6;

    typedef enum logic {
        MODE_TERMINAL,
        MODE_RATE
    } count_mode_t;

endpackage

`default_nettype wire
